// File: build.f
+incdir+include
verilog/posit_pkg.sv
verilog/posit_unpack.sv
verilog/posit_add_core.sv
verilog/posit_round_pack.sv
verilog/posit_adder_top.sv
verif/tb_posit_adder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the posit adder testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
    -f build.f \
    --top-module tb_posit_adder \
    -o sim_posit_adder \
    && ./obj_dir/sim_posit_adder \
    || exit 1

// File: include/posit_ref_model.svh
// reference posit<16,1> add and subtract for the testbench
// values are signed fixed point with 40 fraction bits, exact for posit<16,1>
// posit_pkg must be compiled ahead of the including file
`ifndef POSIT_REF_MODEL_SVH
`define POSIT_REF_MODEL_SVH

typedef logic signed [127:0] ref_fix_t;

// exact value of one posit, nar reads as zero
function automatic ref_fix_t ref_decode(input posit_pkg::posit_t p);
    posit_pkg::posit_t mag;
    logic [14:0]       body;
    logic [14:0]       rem;
    int                run;
    int                scale;
    ref_fix_t          val;
    if (p == '0 || p == posit_pkg::posit_nar)
        return '0;
    mag  = p[15] ? -p : p;
    body = mag[14:0];
    run  = 0;
    while (run < 15 && body[14 - run] == body[14])
        run++;
    rem   = body << (run + 1);
    scale = 2 * (body[14] ? run - 1 : -run) + int'(rem[14]);
    // hidden one over 14 fraction places, lowest two bits are always zero here
    val = ref_fix_t'({1'b1, rem[13:0]}) <<< (scale + 28);
    val = val >>> 2;
    return p[15] ? -val : val;
endfunction

// nearest posit with ties to even, saturating at maxpos and minpos
function automatic posit_pkg::posit_t ref_encode(input ref_fix_t v);
    ref_fix_t          mag;
    int                msb;
    int                scale;
    int                k;
    logic [129:0]      win;
    logic [14:0]       body;
    logic              guard;
    logic              sticky;
    posit_pkg::posit_t res;
    if (v == '0)
        return '0;
    mag = (v < 0) ? -v : v;
    msb = 127;
    while (!mag[msb])
        msb--;
    scale = msb - 40;
    if (scale > 28)
        res = posit_pkg::posit_maxpos;
    else if (scale < -28)
        res = posit_pkg::posit_minpos;
    else
    begin
        k   = scale >>> 1;
        mag = mag << (127 - msb);
        // regime seed, exponent, every fraction bit
        win    = {(k < 0) ? 2'b01 : 2'b10, scale[0], mag[126:0]};
        win    = $signed(win) >>> ((k < 0) ? -k - 1 : k);
        body   = win[129:115];
        guard  = win[114];
        sticky = |win[113:0];
        body   = body + 15'(guard & (body[0] | sticky));
        res    = {1'b0, body};
    end
    return (v < 0) ? -res : res;
endfunction

// exact a+b or a-b rounded back to a posit
function automatic posit_pkg::posit_t ref_add
(
    input posit_pkg::posit_t a,
    input posit_pkg::posit_t b,
    input logic              subtract
);
    if (a == posit_pkg::posit_nar || b == posit_pkg::posit_nar)
        return posit_pkg::posit_nar;
    if (subtract)
        return ref_encode(ref_decode(a) - ref_decode(b));
    return ref_encode(ref_decode(a) + ref_decode(b));
endfunction

`endif

// File: verif/tb_posit_adder.sv
// directed testbench for the posit<16,1> adder pipeline
// inputs change on the falling edge, outputs are sampled there too
// stops at the first mismatch, every wait is bounded
module tb_posit_adder;

    timeunit 1ns;
    timeprecision 100ps;

    `include "posit_ref_model.svh"

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid;
    posit_pkg::posit_t operand_a;
    posit_pkg::posit_t operand_b;
    logic              subtract;
    logic              out_valid;
    posit_pkg::posit_t result;

    // random stream for the pipelined run
    int                seed = 32'h5548_3a5b;
    string             test_name;

    posit_adder_top DUT
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .subtract  (subtract),
        .out_valid (out_valid),
        .result    (result)
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////
    // reporting
    ////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_posit
    (
        input string             name,
        input posit_pkg::posit_t got,
        input posit_pkg::posit_t exp
    );
        if (got !== exp)
            stop_with_failure($sformatf("** Error: %s = %h, expected %h in %s",
                                        name, got, exp, test_name));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("** Error: %s = %h, expected %h in %s",
                                        name, got, exp, test_name));
    endtask

    ////////////////////
    // single operations
    ////////////////////

    // one strobe, then wait for out_valid and check the 3 cycle latency
    task automatic issue_and_wait
    (
        input  posit_pkg::posit_t a,
        input  posit_pkg::posit_t b,
        input  logic              sub,
        output posit_pkg::posit_t got
    );
        int waited;
        @(negedge clk);
        operand_a = a;
        operand_b = b;
        subtract  = sub;
        in_valid  = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 1;
        while (out_valid !== 1'b1)
        begin
            if (waited >= 20)
                stop_with_failure($sformatf("no out_valid within 20 cycles in %s", test_name));
            @(negedge clk);
            waited++;
        end
        if (waited != 3)
            stop_with_failure($sformatf("out_valid came %0d cycles after in_valid in %s",
                                        waited, test_name));
        got = result;
    endtask

    // hand-derived answer, also held against the reference model
    task automatic check_known
    (
        input posit_pkg::posit_t a,
        input posit_pkg::posit_t b,
        input logic              sub,
        input posit_pkg::posit_t exp
    );
        posit_pkg::posit_t got;
        issue_and_wait(a, b, sub, got);
        check_posit("result", got, exp);
        check_posit("ref_add", ref_add(a, b, sub), exp);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_idle_and_latency();
        posit_pkg::posit_t got;
        test_name = "idle and latency";
        // nothing in flight after reset
        repeat (8)
        begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
        end
        // 1.0 + 1.0 is 2.0
        issue_and_wait(16'h4000, 16'h4000, 1'b0, got);
        check_posit("result", got, 16'h5000);
        check_posit("ref_add", ref_add(16'h4000, 16'h4000, 1'b0), 16'h5000);
        // one strobe in, exactly one out
        repeat (6)
        begin
            @(negedge clk);
            check_flag("out_valid", out_valid, 1'b0);
        end
    endtask

    task automatic test_special_cases();
        posit_pkg::posit_t xs [6] = '{16'h4000, 16'hC000, 16'h1234,
                                      16'h7FFF, 16'h0001, 16'hABCD};
        posit_pkg::posit_t neg;
        test_name = "special cases";
        check_known(16'h8000, 16'h8000, 1'b0, 16'h8000);
        foreach (xs[i])
        begin
            neg = -xs[i];
            check_known(16'h8000, xs[i], 1'b0, 16'h8000);
            check_known(xs[i], 16'h8000, 1'b1, 16'h8000);
            check_known(16'h0000, xs[i], 1'b0, xs[i]);
            // zero minus x flips the sign
            check_known(16'h0000, xs[i], 1'b1, neg);
            check_known(xs[i], 16'h0000, 1'b1, xs[i]);
            check_known(xs[i], xs[i], 1'b1, 16'h0000);
        end
    endtask

    // ties at several regime lengths, even and odd last bit
    task automatic test_rounding();
        test_name = "rounding ties";
        // half ulp of 1.0 is 2^-13, 16'h00C0
        check_known(16'h4000, 16'h00C0, 1'b0, 16'h4000);
        check_known(16'h4001, 16'h00C0, 1'b0, 16'h4002);
        check_known(16'h4002, 16'h00C0, 1'b0, 16'h4002);
        check_known(16'h4003, 16'h00C0, 1'b0, 16'h4004);
        check_known(16'h4001, 16'h00C0, 1'b1, 16'h4000);
        // scale 1, half ulp 2^-12
        check_known(16'h5000, 16'h0100, 1'b0, 16'h5000);
        check_known(16'h5001, 16'h0100, 1'b0, 16'h5002);
        // scale 4, only 10 fraction bits
        check_known(16'h7000, 16'h0600, 1'b0, 16'h7000);
        check_known(16'h7001, 16'h0600, 1'b0, 16'h7002);
        // negative mirrors
        check_known(16'hC000, 16'h00C0, 1'b1, 16'hC000);
        check_known(16'hBFFF, 16'h00C0, 1'b1, 16'hBFFE);
    endtask

    task automatic test_saturation();
        test_name = "saturation";
        check_known(16'h7FFF, 16'h7FFF, 1'b0, 16'h7FFF);
        check_known(16'h8001, 16'h8001, 1'b0, 16'h8001);
        check_known(16'h7FFF, 16'h8001, 1'b1, 16'h7FFF);
        // exact cancellation is the only way to zero
        check_known(16'h0001, 16'h0001, 1'b1, 16'h0000);
        check_known(16'hFFFF, 16'h0001, 1'b0, 16'h0000);
        // tiny sums near minpos land on 2^-26, never on zero
        check_known(16'h0001, 16'h0001, 1'b0, 16'h0002);
        check_known(16'h0002, 16'h0001, 1'b1, 16'h0002);
        check_known(16'h0001, 16'h0002, 1'b1, 16'hFFFE);
        check_known(16'h0003, 16'h0002, 1'b1, 16'h0002);
        check_known(16'hFFFF, 16'hFFFF, 1'b0, 16'hFFFE);
        check_known(16'hFFFE, 16'hFFFF, 1'b1, 16'hFFFE);
    endtask

    // one new operation per cycle, results in order 3 cycles later
    task automatic test_back_to_back();
        posit_pkg::posit_t exp_q [$];
        int                issue_q [$];
        posit_pkg::posit_t exp;
        logic [31:0]       rnd;
        int                issued;
        int                received;
        int                tick;
        int                at;
        test_name = "back-to-back random";
        issued    = 0;
        received  = 0;
        tick      = 0;
        while (received < 200)
        begin
            @(negedge clk);
            // sample first, then drive the next operation
            if (out_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                    stop_with_failure("out_valid seen with no operation in flight");
                exp = exp_q.pop_front();
                at  = issue_q.pop_front();
                if (tick - at != 3)
                    stop_with_failure($sformatf("result %0d came %0d cycles after its strobe",
                                                received, tick - at));
                check_posit("result", result, exp);
                received++;
            end
            if (issued < 200)
            begin
                rnd       = $random(seed);
                operand_a = rnd[15:0];
                operand_b = rnd[31:16];
                rnd       = $random(seed);
                subtract  = rnd[0];
                in_valid  = 1'b1;
                exp_q.push_back(ref_add(operand_a, operand_b, subtract));
                issue_q.push_back(tick);
                issued++;
            end
            else
                in_valid = 1'b0;
            if (tick > 220)
                stop_with_failure("back-to-back results did not all arrive in time");
            tick++;
        end
        in_valid = 1'b0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        operand_a = '0;
        operand_b = '0;
        subtract  = 1'b0;
        test_name = "reset";
        // reset over two rising edges
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        test_idle_and_latency();
        test_special_cases();
        test_rounding();
        test_saturation();
        test_back_to_back();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: verilog/posit_adder_top.sv
// posit<16,1> adder, three cycles from in_valid to out_valid
// a new operation may enter every cycle and no back-pressure exists
// result holds its value only with out_valid, capture it then
module posit_adder_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  posit_pkg::posit_t operand_a,
    input  posit_pkg::posit_t operand_b,
    input  logic              subtract,
    output logic              out_valid,
    output posit_pkg::posit_t result
);

    // unpack to core
    logic                 stage1_valid;
    logic                 a_sign;
    posit_pkg::scale_t    a_scale;
    posit_pkg::sig_t      a_sig;
    logic                 a_zero;
    logic                 a_nar;
    logic                 b_sign;
    posit_pkg::scale_t    b_scale;
    posit_pkg::sig_t      b_sig;
    logic                 b_zero;
    logic                 b_nar;
    posit_pkg::posit_t    a_raw;
    posit_pkg::posit_t    b_raw;

    // core to round/pack
    logic                 stage2_valid;
    logic                 sum_sign;
    posit_pkg::scale_t    sum_scale;
    posit_pkg::wide_sig_t sum_sig;
    logic                 special_valid;
    posit_pkg::posit_t    special_value;

    ////////////////////
    // pipeline
    ////////////////////

    // port names match the wires above
    posit_unpack u_unpack (.*);

    posit_add_core u_add_core (.*);

    posit_round_pack u_round_pack (.*);

endmodule

// File: verilog/posit_round_pack.sv
// last pipeline stage, one cycle
// expects a normalized significand with the hidden one at bit 16
// results beyond maxpos or below minpos saturate and never become zero or nar
module posit_round_pack
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stage2_valid,
    input  logic                 sum_sign,
    input  posit_pkg::scale_t    sum_scale,
    input  posit_pkg::wide_sig_t sum_sig,
    input  logic                 special_valid,
    input  posit_pkg::posit_t    special_value,
    output logic                 out_valid,
    output posit_pkg::posit_t    result
);

    // scale of maxpos, minpos is its mirror
    localparam int scale_limit = 28;

    logic signed [6:0]  regime_k;
    logic [1:0]         seed;
    logic [3:0]         shift_amt;
    logic signed [33:0] window;
    logic signed [33:0] shifted;
    logic [14:0]        body;
    logic               lsb;
    logic               guard;
    logic               sticky;
    logic               round_up;
    logic [14:0]        body_rnd;
    posit_pkg::posit_t  magnitude;
    posit_pkg::posit_t  result_d;

    always_comb
    begin
        ////////////////////
        // regime build
        ////////////////////
        // floor of scale/2
        regime_k  = sum_scale >>> 1;
        // k>=0 gives ones then 0, k<0 gives zeros then 1
        seed      = regime_k[6] ? 2'b01 : 2'b10;
        // sign fill of the shift stretches the seed into the full run
        shift_amt = regime_k[6] ? ~regime_k[3:0] : regime_k[3:0];

        // seed, exponent, fraction, grs, room for the shift
        window  = {seed, sum_scale[posit_pkg::posit_es-1:0], sum_sig[15:0], 15'd0};
        shifted = window >>> shift_amt;

        ////////////////////
        // round to nearest even
        ////////////////////
        body     = shifted[33:19];
        lsb      = shifted[19];
        guard    = shifted[18];
        sticky   = |shifted[17:0];
        round_up = guard & (lsb | sticky);
        // body of all ones only occurs with guard clear
        body_rnd = body + 15'(round_up);

        // clamp outside the representable scale range
        if (sum_scale > scale_limit)
            magnitude = posit_pkg::posit_maxpos;
        else if (sum_scale < -scale_limit)
            magnitude = posit_pkg::posit_minpos;
        else
            magnitude = {1'b0, body_rnd};

        // negative posits by two's complement
        if (special_valid)
            result_d = special_value;
        else if (sum_sign)
            result_d = -magnitude;
        else
            result_d = magnitude;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            result    <= '0;
        end
        else
        begin
            out_valid <= stage2_valid;
            if (stage2_valid)
                result <= result_d;
        end
    end

endmodule

// File: verilog/posit_add_core.sv
// second pipeline stage, one cycle
// sum_sig is normalized with the hidden one at bit 16 and sticky in bit 0
// special_value wins downstream whenever special_valid is set
module posit_add_core
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stage1_valid,
    input  logic                 a_sign,
    input  posit_pkg::scale_t    a_scale,
    input  posit_pkg::sig_t      a_sig,
    input  logic                 a_zero,
    input  logic                 a_nar,
    input  logic                 b_sign,
    input  posit_pkg::scale_t    b_scale,
    input  posit_pkg::sig_t      b_sig,
    input  logic                 b_zero,
    input  logic                 b_nar,
    input  posit_pkg::posit_t    a_raw,
    input  posit_pkg::posit_t    b_raw,
    output logic                 stage2_valid,
    output logic                 sum_sign,
    output posit_pkg::scale_t    sum_scale,
    output posit_pkg::wide_sig_t sum_sig,
    output logic                 special_valid,
    output posit_pkg::posit_t    special_value
);

    // swapped operands, larger magnitude first
    logic                 a_first;
    logic                 big_sign;
    logic                 small_sign;
    posit_pkg::scale_t    big_scale;
    posit_pkg::scale_t    small_scale;
    posit_pkg::sig_t      big_sig;
    posit_pkg::sig_t      small_sig;

    // alignment
    logic [6:0]           diff;
    logic [33:0]          shift_win;
    logic [16:0]          small_aligned;
    logic                 small_sticky;
    posit_pkg::wide_sig_t big_ext;
    posit_pkg::wide_sig_t small_ext;

    // sum and normalization
    posit_pkg::wide_sig_t raw_sum;
    posit_pkg::wide_sig_t norm_sig;
    posit_pkg::scale_t    norm_scale;
    logic [4:0]           lz;
    logic                 lz_done;

    // special results
    logic                 spec;
    posit_pkg::posit_t    spec_value;

    always_comb
    begin
        ////////////////////
        // swap
        ////////////////////
        a_first     = (a_scale > b_scale) || (a_scale == b_scale && a_sig >= b_sig);
        big_sign    = a_first ? a_sign  : b_sign;
        small_sign  = a_first ? b_sign  : a_sign;
        big_scale   = a_first ? a_scale : b_scale;
        small_scale = a_first ? b_scale : a_scale;
        big_sig     = a_first ? a_sig   : b_sig;
        small_sig   = a_first ? b_sig   : a_sig;

        ////////////////////
        // align
        ////////////////////
        // never negative after the swap, at most 56
        diff          = 7'(big_scale - small_scale);
        shift_win     = {small_sig, 3'b000, 17'd0} >> diff;
        small_aligned = shift_win[33:17];
        small_sticky  = |shift_win[16:0];
        // whole significand pushed out of the window
        if (diff > 7'd33)
            small_sticky = 1'b1;
        big_ext   = {1'b0, big_sig, 3'b000};
        small_ext = {1'b0, small_aligned[16:1], small_aligned[0] | small_sticky};

        // effective subtraction when signs differ
        if (big_sign != small_sign)
            raw_sum = big_ext - small_ext;
        else
            raw_sum = big_ext + small_ext;

        ////////////////////
        // normalize
        ////////////////////
        lz      = 5'd0;
        lz_done = 1'b0;
        for (int i = 16; i >= 0; i--)
        begin
            if (!lz_done && !raw_sum[i])
                lz = lz + 5'd1;
            else
                lz_done = 1'b1;
        end
        if (raw_sum[17])
        begin
            // carry out, one step right and keep the lost bit as sticky
            norm_sig   = {1'b0, raw_sum[17:2], raw_sum[1] | raw_sum[0]};
            norm_scale = big_scale + 7'sd1;
        end
        else
        begin
            // large shifts only follow near cancellation with no sticky
            norm_sig   = raw_sum << lz;
            norm_scale = big_scale - posit_pkg::scale_t'(lz);
        end

        ////////////////////
        // special cases
        ////////////////////
        spec       = 1'b1;
        spec_value = '0;
        if (a_nar || b_nar)
            spec_value = posit_pkg::posit_nar;
        else if (a_zero)
            // flipped sign on b means the op was a-b
            spec_value = (b_sign ^ b_raw[posit_pkg::posit_n-1]) ? -b_raw : b_raw;
        else if (b_zero)
            spec_value = a_raw;
        else if (raw_sum == '0)
            spec_value = '0;
        else
            spec = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stage2_valid  <= 1'b0;
            sum_sign      <= 1'b0;
            sum_scale     <= '0;
            sum_sig       <= '0;
            special_valid <= 1'b0;
            special_value <= '0;
        end
        else
        begin
            stage2_valid <= stage1_valid;
            if (stage1_valid)
            begin
                sum_sign      <= big_sign;
                sum_scale     <= norm_scale;
                sum_sig       <= norm_sig;
                special_valid <= spec;
                special_value <= spec_value;
            end
        end
    end

endmodule

// File: verilog/posit_unpack.sv
// first pipeline stage, one cycle
// scale and sig carry no meaning when the zero or nar flag is set
// b_sign is already inverted for subtraction
module posit_unpack
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  posit_pkg::posit_t operand_a,
    input  posit_pkg::posit_t operand_b,
    input  logic              subtract,
    output logic              stage1_valid,
    output logic              a_sign,
    output posit_pkg::scale_t a_scale,
    output posit_pkg::sig_t   a_sig,
    output logic              a_zero,
    output logic              a_nar,
    output logic              b_sign,
    output posit_pkg::scale_t b_scale,
    output posit_pkg::sig_t   b_sig,
    output logic              b_zero,
    output logic              b_nar,
    output posit_pkg::posit_t a_raw,
    output posit_pkg::posit_t b_raw
);

    // decoded fields ahead of the stage register
    posit_pkg::scale_t a_scale_d;
    posit_pkg::scale_t b_scale_d;
    posit_pkg::sig_t   a_sig_d;
    posit_pkg::sig_t   b_sig_d;

    ////////////////////
    // field decode
    ////////////////////

    // regime run, exponent bit and fraction of one operand
    function automatic void decode
    (
        input  posit_pkg::posit_t p,
        output posit_pkg::scale_t scale,
        output posit_pkg::sig_t   sig
    );
        posit_pkg::posit_t mag;
        logic [14:0]       body;
        logic [14:0]       rem;
        logic              run_bit;
        logic              done;
        logic [4:0]        run;
        int                k;
        // negative values are stored as two's complement
        mag     = p[posit_pkg::posit_n-1] ? -p : p;
        body    = mag[14:0];
        run_bit = body[14];
        run     = 5'd0;
        done    = 1'b0;
        // leading run of identical regime bits
        for (int i = 14; i >= 0; i--)
        begin
            if (!done && body[i] == run_bit)
                run = run + 5'd1;
            else
                done = 1'b1;
        end
        // run of ones counts from zero, run of zeros is negative
        k = run_bit ? int'(run) - 1 : -int'(run);
        // drop run and terminator so the exponent lands on top
        rem   = body << (run + 5'd1);
        scale = posit_pkg::scale_t'(2 * k + int'(rem[14]));
        // at most 12 real fraction bits, lowest stays zero
        sig   = {1'b1, rem[13:1]};
    endfunction

    always_comb
    begin
        decode(operand_a, a_scale_d, a_sig_d);
        decode(operand_b, b_scale_d, b_sig_d);
    end

    ////////////////////
    // stage register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stage1_valid <= 1'b0;
            a_sign       <= 1'b0;
            a_scale      <= '0;
            a_sig        <= '0;
            a_zero       <= 1'b0;
            a_nar        <= 1'b0;
            b_sign       <= 1'b0;
            b_scale      <= '0;
            b_sig        <= '0;
            b_zero       <= 1'b0;
            b_nar        <= 1'b0;
            a_raw        <= '0;
            b_raw        <= '0;
        end
        else
        begin
            stage1_valid <= in_valid;
            if (in_valid)
            begin
                a_sign  <= operand_a[posit_pkg::posit_n-1];
                a_scale <= a_scale_d;
                a_sig   <= a_sig_d;
                a_zero  <= (operand_a == '0);
                a_nar   <= (operand_a == posit_pkg::posit_nar);
                // a-b becomes a+(-b)
                b_sign  <= operand_b[posit_pkg::posit_n-1] ^ subtract;
                b_scale <= b_scale_d;
                b_sig   <= b_sig_d;
                b_zero  <= (operand_b == '0);
                b_nar   <= (operand_b == posit_pkg::posit_nar);
                a_raw   <= operand_a;
                b_raw   <= operand_b;
            end
        end
    end

endmodule

// File: verilog/posit_pkg.sv
// posit<16,1> widths, field types and special encodings
// field types are fixed at n=16, es=1 and do not follow other values
package posit_pkg;

    // word width and exponent field width
    localparam int posit_n  = 16;
    localparam int posit_es = 1;

    ////////////////////
    // field types
    ////////////////////

    // one posit encoding
    typedef logic [posit_n-1:0] posit_t;

    // combined scale 2k+e, two's complement
    typedef logic signed [6:0] scale_t;

    // hidden one then 13 fraction bits
    typedef logic [13:0] sig_t;

    // overflow, hidden, 13 fraction bits, guard, round, sticky
    typedef logic [17:0] wide_sig_t;

    ////////////////////
    // special encodings
    ////////////////////

    // not-a-real, sign bit alone
    localparam posit_t posit_nar    = 16'h8000;

    // largest and smallest positive values
    localparam posit_t posit_maxpos = 16'h7FFF;
    localparam posit_t posit_minpos = 16'h0001;

endpackage
